// ==== tb.f ====
src/usb_tx_pkg.sv
src/stream_fifo.sv
src/frame_gate.sv
src/skid_loader.sv
src/crc16_appender.sv
src/usb_tx_path.sv
verification/usb_tx_path_assertions.sv
verification/usb_tx_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 --top-module usb_tx_path_tb \
    -f tb.f -o usb_tx_path_sim || { echo "build error"; exit 1; }

./obj_dir/usb_tx_path_sim +verilator+error+limit+100 2>&1 | tee sim.log

grep -q "TB FAILED" sim.log && { echo "simulation reported failure"; exit 1; } \
    || grep -q "TB PASSED" sim.log || { echo "simulation ended early"; exit 1; }

// ==== verification/usb_tx_path_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_tx_path_tb import usb_tx_pkg::*; ();

    localparam int FIFO_DEPTH = 16;

    logic  clock = 1'b0;
    logic  reset;
    logic  s_tvalid;
    logic  s_tready;
    logic  s_tlast;
    byte_t s_tdata;
    logic  pid_valid;
    logic  pid_ready;
    byte_t pid;
    logic  pid_error;
    logic  m_tvalid;
    logic  m_tready;
    logic  m_tlast;
    byte_t m_tdata;

    integer      seed;
    integer      saved_seed;
    logic        stall_on;           // Random m_tready when set
    logic [31:0] stall_rnd;
    int          error_count  = 0;
    int          test_count   = 0;
    int          failed_tests = 0;
    int          cycle_count  = 0;
    int          cycle_limit  = 200;  // Grows by 8 cycles per stimulus byte
    int          pulse_count  = 0;    // Cycles with pid_error high
    int          full_count   = 0;    // Cycles where a payload byte waits on s_tready
    int          full_start;
    int          test_errors;
    int          test_pulses;
    byte_t       pay_data_q[$];
    logic        pay_last_q[$];
    byte_t       pid_q[$];
    byte_t       exp_data_q[$];
    logic        exp_last_q[$];

    always #5 clock = ~clock;

    usb_tx_path #(.FIFO_DEPTH(FIFO_DEPTH)) i_dut (.*);

    // Whole byte folded into the low end, then eight LSB-first shifts
    function automatic crc16_t crc16_ref(byte_t data[$]);
        crc16_t c;
        c = CRC16_INIT;
        foreach (data[i]) begin
            c = c ^ {8'h00, data[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ CRC16_POLY_REFLECTED) : (c >> 1);
            end
        end
        return c;
    endfunction

    task automatic check_byte(string name, byte_t actual, byte_t expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    task automatic check_bit(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, actual, expected);
            error_count++;
        end
    endtask

    // Queues one payload for the FIFO and the packet it should become
    task automatic plan_frame(byte_t pid_value, int len);
        byte_t       payload[$];
        logic [31:0] rnd;
        crc16_t      crc;
        for (int i = 0; i < len; i++) begin
            rnd = $random(seed);
            payload.push_back(rnd[7:0]);
            pay_data_q.push_back(rnd[7:0]);
            pay_last_q.push_back(i == len - 1);
        end
        crc = crc16_ref(payload);
        pid_q.push_back(pid_value);
        exp_data_q.push_back(pid_value);
        exp_last_q.push_back(1'b0);
        foreach (payload[i]) begin
            exp_data_q.push_back(payload[i]);
            exp_last_q.push_back(1'b0);
        end
        exp_data_q.push_back(~crc[7:0]);  // Inverted CRC, low byte first
        exp_last_q.push_back(1'b0);
        exp_data_q.push_back(~crc[15:8]);
        exp_last_q.push_back(1'b1);
        cycle_limit += 8 * (len + 1);
    endtask

    task automatic plan_random_frames(int n);
        logic [31:0] rnd;
        for (int f = 0; f < n; f++) begin
            rnd = $random(seed);
            plan_frame({~rnd[3:0], rnd[3:0]}, int'(rnd[7:4]) + 1);  // 1 to 16 bytes
        end
    endtask

    // Ready is sampled mid-cycle, the byte moves at the next rising edge
    task automatic drive_payload();
        while (pay_data_q.size() > 0) begin
            s_tvalid = 1'b1;
            s_tdata  = pay_data_q.pop_front();
            s_tlast  = pay_last_q.pop_front();
            @(negedge clock);
            while (!s_tready) @(negedge clock);
            @(posedge clock);
            #1;
        end
        s_tvalid = 1'b0;
    endtask

    task automatic drive_pids();
        while (pid_q.size() > 0) begin
            pid_valid = 1'b1;
            pid       = pid_q.pop_front();
            @(negedge clock);
            while (!pid_ready) @(negedge clock);
            @(posedge clock);
            #1;
        end
        pid_valid = 1'b0;
    endtask

    // Sends the queued traffic and waits until every expected byte is out
    task automatic run_traffic(bit payload_first);
        if (payload_first) begin
            drive_payload();
            drive_pids();
        end else begin
            fork
                drive_payload();
                drive_pids();
            join
        end
        while (exp_data_q.size() > 0) @(negedge clock);
        repeat (4) @(posedge clock);
        #1;
    endtask

    task automatic start_test();
        test_errors = error_count;
        test_pulses = pulse_count;
    endtask

    task automatic finish_test(string name, int pulses);
        if (pulse_count - test_pulses != pulses) begin
            $display("pid_error was high for %0d cycles instead of %0d",
                     pulse_count - test_pulses, pulses);
            error_count++;
        end
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: failed with %0d errors", test_count, name,
                     error_count - test_errors);
        end
    endtask

    // Output compare, the sampled byte is accepted at the next rising edge
    always @(negedge clock) begin
        if (!reset && m_tvalid && m_tready) begin
            if (exp_data_q.size() == 0) begin
                $display("output byte 0x%h arrived with no byte expected", m_tdata);
                error_count++;
            end else begin
                check_byte("m_tdata", m_tdata, exp_data_q.pop_front());
                check_bit("m_tlast", m_tlast, exp_last_q.pop_front());
            end
        end
    end

    always @(negedge clock) begin
        cycle_count++;
        if (pid_error) pulse_count++;
        if (!reset && s_tvalid && !s_tready) full_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles with %0d bytes still expected",
                     cycle_count, exp_data_q.size());
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (stall_on) begin
                stall_rnd = $random(seed);
                m_tready  = stall_rnd[0];
            end else begin
                m_tready = 1'b1;
            end
        end
    end

    initial begin
        seed      = 32'h99016eb4;
        stall_on  = 1'b0;
        reset     = 1'b1;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        s_tdata   = '0;
        pid_valid = 1'b0;
        pid       = '0;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test();
        check_bit("m_tvalid", m_tvalid, 1'b0);
        check_bit("pid_error", pid_error, 1'b0);
        check_bit("s_tready", s_tready, 1'b0);
        check_bit("pid_ready", pid_ready, 1'b0);
        @(posedge clock);
        #1;
        check_bit("s_tready", s_tready, 1'b1);
        finish_test("reset state", 0);

        start_test();
        plan_frame(8'hc3, 4);
        run_traffic(1'b0);
        finish_test("single frame", 0);

        start_test();
        saved_seed = seed;
        plan_random_frames(20);
        run_traffic(1'b0);
        finish_test("back-to-back frames", 0);

        start_test();
        seed = saved_seed;  // Same frames as the previous test
        plan_random_frames(20);
        full_start = full_count;
        stall_on   = 1'b1;
        run_traffic(1'b0);
        stall_on = 1'b0;
        if (full_count == full_start) begin
            $display("s_tready never fell while the output was stalled");
            error_count++;
        end
        finish_test("random back-pressure", 0);

        start_test();
        pid_q.push_back(8'h55);  // Upper nibble not inverted
        cycle_limit += 8;
        plan_frame(8'ha5, 6);
        run_traffic(1'b1);
        finish_test("invalid PID", 1);

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 test_count, failed_tests, error_count, i_dut.i_stream_checks.fail_count);
        if (error_count == 0 && i_dut.i_stream_checks.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/usb_tx_path_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_tx_path_assertions import usb_tx_pkg::*; (
    input wire logic  clock,
    input wire logic  reset,
    input wire logic  m_tvalid,
    input wire logic  m_tready,
    input wire logic  m_tlast,
    input wire byte_t m_tdata,
    input wire logic  pid_error
);

    int fail_count = 0;  // Failed assertion count

    // A stalled byte stays on the bus unchanged
    hold_while_stalled: assert property (
        @(posedge clock) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
    ) else begin
        $error("output byte changed or vanished while stalled");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge clock) reset |=> !m_tvalid)
    else begin
        $error("m_tvalid high after a reset cycle");
        fail_count++;
    end

    single_error_pulse: assert property (
        @(posedge clock) disable iff (reset) pid_error |=> !pid_error
    ) else begin
        $error("pid_error high for more than one cycle");
        fail_count++;
    end

endmodule

bind usb_tx_path usb_tx_path_assertions i_stream_checks (
    .clock     (clock),
    .reset     (reset),
    .m_tvalid  (m_tvalid),
    .m_tready  (m_tready),
    .m_tlast   (m_tlast),
    .m_tdata   (m_tdata),
    .pid_error (pid_error)
);

`default_nettype wire

// ==== src/usb_tx_path.sv ====
`timescale 1ns/100ps
`default_nettype none

module usb_tx_path import usb_tx_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic  clock,
    input  wire logic  reset,

    input  wire logic  s_tvalid,
    output wire logic  s_tready,
    input  wire logic  s_tlast,
    input  wire byte_t s_tdata,

    input  wire logic  pid_valid,
    output wire logic  pid_ready,
    input  wire byte_t pid,
    output wire logic  pid_error,

    output wire logic  m_tvalid,
    input  wire logic  m_tready,
    output wire logic  m_tlast,
    output wire byte_t m_tdata
);

    logic  f_tvalid;  // FIFO head
    logic  f_tready;
    logic  f_tlast;
    byte_t f_tdata;
    logic  g_tvalid;  // Released payload
    logic  g_tready;
    logic  g_tlast;
    byte_t g_tdata;
    logic  t_tvalid;  // PID load
    logic  t_tready;
    byte_t t_tdata;
    logic  k_tvalid;  // Ordered PID and payload
    logic  k_tready;
    logic  k_tlast;
    byte_t k_tdata;

    stream_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clock    (clock),
        .reset    (reset),
        .s_tvalid (s_tvalid),
        .s_tready (s_tready),
        .s_tlast  (s_tlast),
        .s_tdata  (s_tdata),
        .m_tvalid (f_tvalid),
        .m_tready (f_tready),
        .m_tlast  (f_tlast),
        .m_tdata  (f_tdata)
    );

    frame_gate u_gate (
        .clock     (clock),
        .reset     (reset),
        .pid_valid (pid_valid),
        .pid_ready (pid_ready),
        .pid       (pid),
        .pid_error (pid_error),
        .f_tvalid  (f_tvalid),
        .f_tready  (f_tready),
        .f_tlast   (f_tlast),
        .f_tdata   (f_tdata),
        .g_tvalid  (g_tvalid),
        .g_tready  (g_tready),
        .g_tlast   (g_tlast),
        .g_tdata   (g_tdata),
        .t_tvalid  (t_tvalid),
        .t_tready  (t_tready),
        .t_tdata   (t_tdata)
    );

    skid_loader #(
        .WIDTH       ($bits(byte_t)),
        .RESET_TDATA (1'b0)
    ) u_skid (
        .clock    (clock),
        .reset    (reset),
        .s_tvalid (g_tvalid),
        .s_tready (g_tready),
        .s_tlast  (g_tlast),
        .s_tdata  (g_tdata),
        .t_tvalid (t_tvalid),
        .t_tready (t_tready),
        .t_tlast  (1'b0),  // A PID never ends a frame
        .t_tdata  (t_tdata),
        .m_tvalid (k_tvalid),
        .m_tready (k_tready),
        .m_tlast  (k_tlast),
        .m_tdata  (k_tdata)
    );

    crc16_appender u_crc (
        .clock    (clock),
        .reset    (reset),
        .k_tvalid (k_tvalid),
        .k_tready (k_tready),
        .k_tlast  (k_tlast),
        .k_tdata  (k_tdata),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tlast  (m_tlast),
        .m_tdata  (m_tdata)
    );

endmodule

`default_nettype wire

// ==== src/crc16_appender.sv ====
`timescale 1ns/100ps
`default_nettype none

module crc16_appender import usb_tx_pkg::*; (
    input  wire logic  clock,
    input  wire logic  reset,

    input  wire logic  k_tvalid,
    output logic       k_tready,
    input  wire logic  k_tlast,
    input  wire byte_t k_tdata,

    output logic       m_tvalid,
    input  wire logic  m_tready,
    output logic       m_tlast,
    output byte_t      m_tdata
);

    typedef enum logic [1:0] {ST_PID, ST_DATA, ST_CRC_LO, ST_CRC_HI} state_t;

    state_t state;
    crc16_t crc;
    logic   out_free;
    logic   k_take;
    logic   crc_out;   // Output slot taken by a CRC byte
    logic   load_out;

    // Reflected CRC, data bits enter LSB first
    function automatic crc16_t crc16_byte(crc16_t value, byte_t data);
        crc16_t r;
        r = value;
        for (int i = 0; i < 8; i++) begin
            if (r[0] ^ data[i]) begin
                r = (r >> 1) ^ CRC16_POLY_REFLECTED;
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    assign out_free = !m_tvalid || m_tready;
    assign k_tready = out_free && (state == ST_PID || state == ST_DATA);
    assign k_take   = k_tvalid && k_tready;
    assign crc_out  = out_free && (state == ST_CRC_LO || state == ST_CRC_HI);
    assign load_out = k_take || crc_out;

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_PID;
            crc      <= CRC16_INIT;
            m_tvalid <= 1'b0;
        end else begin
            m_tvalid <= load_out || (m_tvalid && !m_tready);
            case (state)
                ST_PID: if (k_take) state <= ST_DATA;  // PID stays out of the CRC
                ST_DATA: begin
                    if (k_take) begin
                        crc <= crc16_byte(crc, k_tdata);
                        if (k_tlast) state <= ST_CRC_LO;
                    end
                end
                ST_CRC_LO: if (out_free) state <= ST_CRC_HI;
                default: begin
                    if (out_free) begin
                        state <= ST_PID;
                        crc   <= CRC16_INIT;  // Ready for the next packet
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (k_take) begin
            m_tdata <= k_tdata;
            m_tlast <= 1'b0;  // Frame end moves to the CRC
        end else if (crc_out && state == ST_CRC_LO) begin
            m_tdata <= ~crc[7:0];
            m_tlast <= 1'b0;
        end else if (crc_out) begin
            m_tdata <= ~crc[15:8];
            m_tlast <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/skid_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module skid_loader import usb_tx_pkg::*; #(
    parameter int WIDTH       = $bits(byte_t),
    parameter bit RESET_TDATA = 1'b0
) (
    input  wire logic             clock,
    input  wire logic             reset,

    input  wire logic             s_tvalid,
    output logic                  s_tready,
    input  wire logic             s_tlast,
    input  wire logic [WIDTH-1:0] s_tdata,

    input  wire logic             t_tvalid,
    output logic                  t_tready,
    input  wire logic             t_tlast,
    input  wire logic [WIDTH-1:0] t_tdata,

    output logic                  m_tvalid,
    input  wire logic             m_tready,
    output logic                  m_tlast,
    output logic [WIDTH-1:0]      m_tdata
);

    logic             m_valid_r;
    logic             m_last_r;
    logic [WIDTH-1:0] m_data_r;
    logic             t_valid_r;  // Temporary register full
    logic             t_last_r;
    logic [WIDTH-1:0] t_data_r;
    logic             s_ready_r;
    logic             t_ready_r;

    logic             m_free;
    logic             s_acc;
    logic             t_acc;
    logic             in_acc;
    logic             t_valid_next;
    logic             t_ready_next;

    assign s_tready = s_ready_r;
    assign t_tready = t_ready_r;
    assign m_tvalid = m_valid_r;
    assign m_tlast  = m_last_r;
    assign m_tdata  = m_data_r;

    assign m_free = !m_valid_r || m_tready;  // Output takes a new byte this edge
    assign s_acc  = s_tvalid && s_ready_r;
    assign t_acc  = t_tvalid && t_ready_r;
    assign in_acc = s_acc || t_acc;          // Never both, readies are exclusive

    // Temp holds whatever could not move straight to the output
    assign t_valid_next = !m_free && (t_valid_r || in_acc);

    // A waiting load wins the next free slot over the source
    assign t_ready_next = !t_valid_next && t_tvalid && !t_acc;

    always_ff @(posedge clock) begin
        if (reset) begin
            m_valid_r <= 1'b0;
            t_valid_r <= 1'b0;
            s_ready_r <= 1'b0;
            t_ready_r <= 1'b0;
        end else begin
            m_valid_r <= t_valid_r || in_acc || (m_valid_r && !m_tready);
            t_valid_r <= t_valid_next;
            s_ready_r <= !t_valid_next && !t_ready_next;
            t_ready_r <= t_ready_next;
        end
    end

    always_ff @(posedge clock) begin
        if (RESET_TDATA && reset) begin
            m_data_r <= '0;
            m_last_r <= 1'b0;
        end else if (m_free) begin
            if (t_valid_r) begin
                m_data_r <= t_data_r;  // Drain temp first
                m_last_r <= t_last_r;
            end else if (t_acc) begin
                m_data_r <= t_tdata;
                m_last_r <= t_tlast;
            end else if (s_acc) begin
                m_data_r <= s_tdata;
                m_last_r <= s_tlast;
            end
        end

        if (!t_valid_r && !m_free && in_acc) begin
            t_data_r <= t_acc ? t_tdata : s_tdata;
            t_last_r <= t_acc ? t_tlast : s_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_gate.sv ====
`timescale 1ns/100ps
`default_nettype none

module frame_gate import usb_tx_pkg::*; (
    input  wire logic  clock,
    input  wire logic  reset,

    input  wire logic  pid_valid,
    output logic       pid_ready,
    input  wire byte_t pid,
    output logic       pid_error,

    input  wire logic  f_tvalid,
    output logic       f_tready,
    input  wire logic  f_tlast,
    input  wire byte_t f_tdata,

    output logic       g_tvalid,
    input  wire logic  g_tready,
    output logic       g_tlast,
    output byte_t      g_tdata,

    output logic       t_tvalid,
    input  wire logic  t_tready,
    output byte_t      t_tdata
);

    typedef enum logic {ST_IDLE, ST_PASS} state_t;

    state_t state;
    state_t state_next;
    logic   pid_ok;
    logic   pid_take;
    logic   drop_ready;  // Ready for a rejected PID
    logic   last_taken;

    assign pid_ok    = pid_is_valid(pid);
    assign t_tvalid  = (state == ST_IDLE) && pid_valid && pid_ok;
    assign t_tdata   = pid;
    assign pid_ready = pid_ok ? ((state == ST_IDLE) && t_tready) : drop_ready;
    assign pid_take  = pid_valid && pid_ready;

    // One frame flows straight through while passing
    assign g_tvalid   = (state == ST_PASS) && f_tvalid;
    assign f_tready   = (state == ST_PASS) && g_tready;
    assign g_tlast    = f_tlast;
    assign g_tdata    = f_tdata;
    assign last_taken = g_tvalid && g_tready && f_tlast;

    always_comb begin
        state_next = state;
        if (state == ST_IDLE && t_tvalid && t_tready) begin
            state_next = ST_PASS;  // PID now sits in the skid stage
        end else if (state == ST_PASS && last_taken) begin
            state_next = ST_IDLE;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= ST_IDLE;
            drop_ready <= 1'b0;
            pid_error  <= 1'b0;
        end else begin
            state      <= state_next;
            drop_ready <= (state_next == ST_IDLE) && pid_valid && !pid_ok && !pid_take;
            pid_error  <= pid_take && !pid_ok;  // Single pulse per rejected PID
        end
    end

endmodule

`default_nettype wire

// ==== src/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_fifo import usb_tx_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  wire logic  clock,
    input  wire logic  reset,

    input  wire logic  s_tvalid,
    output logic       s_tready,
    input  wire logic  s_tlast,
    input  wire byte_t s_tdata,

    output logic       m_tvalid,
    input  wire logic  m_tready,
    output logic       m_tlast,
    output byte_t      m_tdata
);

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW + 1)'(DEPTH);

    byte_t         data_mem [DEPTH];
    logic          last_mem [DEPTH];  // Frame end flag per entry
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic          ready_r;
    logic          wr_en;
    logic          rd_en;

    assign wr_en    = s_tvalid && ready_r;
    assign rd_en    = m_tvalid && m_tready;
    assign s_tready = ready_r;
    assign m_tvalid = (count != '0);
    assign m_tdata  = data_mem[rd_ptr];  // Show-ahead head entry
    assign m_tlast  = last_mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (wr_en && !rd_en) begin
            count_next = count + 1'b1;
        end else if (rd_en && !wr_en) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            ready_r <= 1'b0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count   <= count_next;
            ready_r <= (count_next != FULL_COUNT);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= s_tdata;
            last_mem[wr_ptr] <= s_tlast;
        end
    end

endmodule

`default_nettype wire

// ==== src/usb_tx_pkg.sv ====
`default_nettype none

package usb_tx_pkg;

    typedef logic [7:0]  byte_t;   // One stream byte
    typedef logic [15:0] crc16_t;  // CRC shift register

    // USB data CRC, x^16 + x^15 + x^2 + 1, shifted LSB first
    localparam crc16_t CRC16_INIT           = 16'hffff;
    localparam crc16_t CRC16_POLY_REFLECTED = 16'ha001;  // Bit-reversed 16'h8005

    // Upper nibble carries the inverted check copy of the lower nibble
    function automatic logic pid_is_valid(byte_t value);
        return value[7:4] == ~value[3:0];
    endfunction

endpackage

`default_nettype wire
